/* hw/link_monitor.sv */
`default_nettype none
`timescale 1ns/1ns

module link_monitor (
	input  wire logic clk_125mhz,
	input  wire logic arst_n,
	input  wire logic rx_data_valid,
	input  wire logic rx_disparity_err,
	input  wire logic rx_symbol_err,
	input  wire logic cfg_seen,
	input  wire logic idle_match,
	output logic      link_up
);

	pcs_link_pkg::link_timer_t   link_timer;	// Cycles since last idle match
	pcs_link_pkg::error_window_t window_cnt;	// Free running
	pcs_link_pkg::error_count_t  error_count;
	logic                        rx_fault;
	logic                        timer_done;
	logic                        window_end;
	logic                        too_many_errs;

	assign rx_fault = rx_data_valid && (rx_disparity_err || rx_symbol_err);
	assign timer_done = (link_timer ==
		pcs_link_pkg::link_timer_t'(pcs_link_pkg::LINK_TIMER_CYCLES));
	assign window_end = (window_cnt ==
		pcs_link_pkg::error_window_t'(pcs_link_pkg::ERROR_WINDOW_CYCLES - 1));
	assign too_many_errs = window_end &&
		(error_count >= pcs_link_pkg::error_count_t'(pcs_link_pkg::ERROR_LIMIT));

	//////////////////////////////////////////////////
	// Link timer, only runs while the link is up

	always_ff @(posedge clk_125mhz or negedge arst_n) begin
		if (!arst_n)
			link_timer <= '0;
		else if (!link_up || idle_match || timer_done)
			link_timer <= '0;	// Idle seen, restart the 10 ms period
		else
			link_timer <= link_timer + 1'b1;
	end

	//////////////////////////////////////////////////
	// Error window

	always_ff @(posedge clk_125mhz or negedge arst_n) begin
		if (!arst_n) begin
			window_cnt <= '0;
			error_count <= '0;
		end else begin
			window_cnt <= window_cnt + 1'b1;	// Wraps every window
			if (window_end)
				error_count <= rx_fault ? pcs_link_pkg::error_count_t'(1) : '0;
			else if (rx_fault && (error_count != '1))
				error_count <= error_count + 1'b1;	// Saturate at 255
		end
	end

	// Link state
	always_ff @(posedge clk_125mhz or negedge arst_n) begin
		if (!arst_n)
			link_up <= 1'b0;
		else if (!link_up) begin
			if (idle_match)
				link_up <= 1'b1;	// No negotiation, idles are enough
		end else if (cfg_seen || timer_done || too_many_errs)
			link_up <= 1'b0;
	end

endmodule

`default_nettype wire

/* hw/pcs_code_pkg.sv */
`default_nettype none

package pcs_code_pkg;

	typedef logic [7:0] code_group_t;	// One decoded 8b/10b code group

	//////////////////////////////////////////////////
	// Control groups, sent with is_ctl high

	localparam code_group_t K28_5 = 8'hBC;	// Comma, first half of every /I/ and /C/
	localparam code_group_t K27_7 = 8'hFB;	// /S/ start of packet
	localparam code_group_t K29_7 = 8'hFD;	// /T/ end of packet
	localparam code_group_t K23_7 = 8'hF7;	// /R/ carrier extend
	localparam code_group_t K30_7 = 8'hFE;	// /V/ error propagation

	//////////////////////////////////////////////////
	// Data groups, sent with is_ctl low

	localparam code_group_t D16_2 = 8'h50;	// /I2/ second half, keeps disparity
	localparam code_group_t D5_6 = 8'hC5;	// /I1/ second half, flips disparity
	localparam code_group_t D21_5 = 8'hB5;	// /C1/ header
	localparam code_group_t D2_2 = 8'h42;	// /C2/ header

	localparam code_group_t PREAMBLE_BYTE = 8'h55;	// GMII byte standing in for /S/

	// Transmit sequencing FSM, one state per kind of group on the wire
	typedef enum logic [2:0] {
		TX_I2_0  = 3'd0,	// K28.5 of /I2/
		TX_I2_1  = 3'd1,	// D16.2 of /I2/
		TX_START = 3'd2,	// /S/ after finishing an idle
		TX_FRAME = 3'd3,	// Payload bytes
		TX_TERM  = 3'd4,	// First /R/ after /T/
		TX_PAD   = 3'd5,	// Second /R/ for even alignment
		TX_I1_0  = 3'd6,	// K28.5 of /I1/
		TX_I1_1  = 3'd7		// D5.6 of /I1/
	} tx_state_t;

endpackage

`default_nettype wire

/* hw/pcs_link_pkg.sv */
`default_nettype none

package pcs_link_pkg;

	//////////////////////////////////////////////////
	// Link timer

	localparam int unsigned LINK_TIMER_CYCLES = 1_250_000;	// 10 ms at 125 MHz
	localparam int unsigned LINK_TIMER_BITS = $clog2(LINK_TIMER_CYCLES + 1);
	typedef logic [LINK_TIMER_BITS-1:0] link_timer_t;

	//////////////////////////////////////////////////
	// Code error monitor

	localparam int unsigned ERROR_WINDOW_CYCLES = 65_536;	// Power of two, counter wraps
	localparam int unsigned ERROR_WINDOW_BITS = $clog2(ERROR_WINDOW_CYCLES);
	typedef logic [ERROR_WINDOW_BITS-1:0] error_window_t;

	localparam int unsigned ERROR_LIMIT = 128;	// Bad groups per window that kill the link
	typedef logic [7:0] error_count_t;	// Saturates at 255

	// Idle detection
	localparam int unsigned IDLE_MATCH_COUNT = 4;	// Consecutive /I2/ for a match
	typedef logic [$clog2(IDLE_MATCH_COUNT)-1:0] idle_count_t;

endpackage

`default_nettype wire

/* hw/pcs_top.sv */
`default_nettype none
`timescale 1ns/1ns

module pcs_top (
	input  wire logic                      clk_125mhz,
	input  wire logic                      arst_n,

	// RX code groups from the SERDES
	input  wire logic                      rx_data_valid,
	input  wire logic                      rx_data_is_ctl,
	input  wire pcs_code_pkg::code_group_t rx_data,
	input  wire logic                      rx_disparity_err,
	input  wire logic                      rx_symbol_err,

	output logic                           link_up,

	// GMII receive
	output logic                           gmii_rx_en,
	output logic                           gmii_rx_er,
	output pcs_code_pkg::code_group_t      gmii_rx_data,

	// GMII transmit
	input  wire logic                      gmii_tx_en,
	input  wire pcs_code_pkg::code_group_t gmii_tx_data,

	// TX code groups to the SERDES
	input  wire logic                      tx_disparity_negative,
	output logic                           tx_data_is_ctl,
	output pcs_code_pkg::code_group_t      tx_data
);

	logic cfg_seen;	// Far end sent a /C/ set
	logic idle_match;	// Run of /I2/ on the RX side

	rx_ordered_set_parser parser_i (
		.clk_125mhz     (clk_125mhz),
		.arst_n         (arst_n),
		.rx_data_valid  (rx_data_valid),
		.rx_data_is_ctl (rx_data_is_ctl),
		.rx_data        (rx_data),
		.cfg_seen       (cfg_seen),
		.idle_match     (idle_match)
	);

	link_monitor link_monitor_i (
		.clk_125mhz       (clk_125mhz),
		.arst_n           (arst_n),
		.rx_data_valid    (rx_data_valid),
		.rx_disparity_err (rx_disparity_err),
		.rx_symbol_err    (rx_symbol_err),
		.cfg_seen         (cfg_seen),
		.idle_match       (idle_match),
		.link_up          (link_up)
	);

	rx_frame_decoder decoder_i (
		.clk_125mhz     (clk_125mhz),
		.arst_n         (arst_n),
		.rx_data_valid  (rx_data_valid),
		.rx_data_is_ctl (rx_data_is_ctl),
		.rx_data        (rx_data),
		.idle_match     (idle_match),
		.gmii_rx_en     (gmii_rx_en),
		.gmii_rx_er     (gmii_rx_er),
		.gmii_rx_data   (gmii_rx_data)
	);

	tx_frame_encoder encoder_i (
		.clk_125mhz            (clk_125mhz),
		.arst_n                (arst_n),
		.link_up               (link_up),
		.gmii_tx_en            (gmii_tx_en),
		.gmii_tx_data          (gmii_tx_data),
		.tx_disparity_negative (tx_disparity_negative),
		.tx_data_is_ctl        (tx_data_is_ctl),
		.tx_data               (tx_data)
	);

endmodule

`default_nettype wire

/* hw/rx_frame_decoder.sv */
`default_nettype none
`timescale 1ns/1ns

module rx_frame_decoder (
	input  wire logic                      clk_125mhz,
	input  wire logic                      arst_n,
	input  wire logic                      rx_data_valid,
	input  wire logic                      rx_data_is_ctl,
	input  wire pcs_code_pkg::code_group_t rx_data,
	input  wire logic                      idle_match,
	output logic                           gmii_rx_en,
	output logic                           gmii_rx_er,
	output pcs_code_pkg::code_group_t      gmii_rx_data
);

	logic is_start;

	assign is_start = rx_data_is_ctl && (rx_data == pcs_code_pkg::K27_7);

	//////////////////////////////////////////////////
	// Frame state and error flag

	always_ff @(posedge clk_125mhz or negedge arst_n) begin
		if (!arst_n) begin
			gmii_rx_en <= 1'b0;
			gmii_rx_er <= 1'b0;
		end else begin
			gmii_rx_er <= 1'b0;	// Error only lasts one byte
			if (rx_data_valid) begin
				if (is_start)
					gmii_rx_en <= 1'b1;
				else if (gmii_rx_en && idle_match) begin
					gmii_rx_en <= 1'b0;	// Lost /T/, idles already back
					gmii_rx_er <= 1'b1;
				end else if (gmii_rx_en && rx_data_is_ctl) begin
					if (rx_data == pcs_code_pkg::K29_7)
						gmii_rx_en <= 1'b0;
					else if (rx_data == pcs_code_pkg::K30_7)
						gmii_rx_er <= 1'b1;	// /V/ from the far end
					// Other K codes in a frame are dropped
				end
			end
		end
	end

	// Byte lane
	always_ff @(posedge clk_125mhz) begin
		if (rx_data_valid) begin
			if (is_start)
				gmii_rx_data <= pcs_code_pkg::PREAMBLE_BYTE;	// /S/ replaced a preamble byte
			else if (gmii_rx_en && !rx_data_is_ctl)
				gmii_rx_data <= rx_data;
		end
	end

endmodule

`default_nettype wire

/* hw/rx_ordered_set_parser.sv */
`default_nettype none
`timescale 1ns/1ns

module rx_ordered_set_parser (
	input  wire logic                      clk_125mhz,
	input  wire logic                      arst_n,
	input  wire logic                      rx_data_valid,
	input  wire logic                      rx_data_is_ctl,
	input  wire pcs_code_pkg::code_group_t rx_data,
	output logic                           cfg_seen,	// Pulse per complete /C/ set
	output logic                           idle_match	// Level, run of /I2/ present
);

	typedef enum logic [1:0] {
		CFG_WAIT_COMMA,	// Hunt for K28.5
		CFG_HEADER,		// Expect D21.5 or D2.2
		CFG_REG_0,		// Low config byte
		CFG_REG_1		// High config byte
	} cfg_state_t;

	cfg_state_t                  cfg_state;
	logic                        is_comma;
	logic                        is_i2_tail;
	logic                        is_cfg_header;
	logic                        last_was_comma;	// Previous valid group was K28.5
	pcs_link_pkg::idle_count_t   idle_count;

	assign is_comma = rx_data_is_ctl && (rx_data == pcs_code_pkg::K28_5);
	assign is_i2_tail = !rx_data_is_ctl && (rx_data == pcs_code_pkg::D16_2);
	assign is_cfg_header = !rx_data_is_ctl &&
		((rx_data == pcs_code_pkg::D21_5) || (rx_data == pcs_code_pkg::D2_2));

	//////////////////////////////////////////////////
	// /C1/ and /C2/ ordered set framing

	always_ff @(posedge clk_125mhz or negedge arst_n) begin
		if (!arst_n) begin
			cfg_state <= CFG_WAIT_COMMA;
			cfg_seen <= 1'b0;
		end else begin
			cfg_seen <= 1'b0;
			if (rx_data_valid) begin
				case (cfg_state)
					CFG_WAIT_COMMA: if (is_comma) cfg_state <= CFG_HEADER;
					CFG_HEADER: begin
						if (is_cfg_header)
							cfg_state <= CFG_REG_0;
						else if (!is_comma)	// Repeated comma stays here
							cfg_state <= CFG_WAIT_COMMA;
					end
					CFG_REG_0: cfg_state <= rx_data_is_ctl ? CFG_WAIT_COMMA : CFG_REG_1;
					CFG_REG_1: begin
						cfg_state <= CFG_WAIT_COMMA;
						cfg_seen <= !rx_data_is_ctl;	// Config bytes are never K codes
					end
					default: cfg_state <= CFG_WAIT_COMMA;
				endcase
			end
		end
	end

	//////////////////////////////////////////////////
	// Comma follower, counts K28.5/D16.2 pairs

	always_ff @(posedge clk_125mhz or negedge arst_n) begin
		if (!arst_n) begin
			last_was_comma <= 1'b0;
			idle_count <= '0;
			idle_match <= 1'b0;
		end else begin
			if (rx_data_valid) begin
				last_was_comma <= is_comma;
				if (is_i2_tail && last_was_comma) begin
					if (idle_count == pcs_link_pkg::idle_count_t'(pcs_link_pkg::IDLE_MATCH_COUNT - 1))
						idle_match <= 1'b1;	// Count holds, match stays up
					else
						idle_count <= idle_count + 1'b1;
				end else if (!is_comma || last_was_comma) begin
					idle_count <= '0;	// Anything but an /I2/ breaks the run
					idle_match <= 1'b0;
				end
			end
			if (cfg_seen) begin	// Far end is negotiating, no idles
				idle_count <= '0;
				idle_match <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

/* hw/tx_frame_encoder.sv */
`default_nettype none
`timescale 1ns/1ns

module tx_frame_encoder (
	input  wire logic                      clk_125mhz,
	input  wire logic                      arst_n,
	input  wire logic                      link_up,
	input  wire logic                      gmii_tx_en,
	input  wire pcs_code_pkg::code_group_t gmii_tx_data,
	input  wire logic                      tx_disparity_negative,	// From the serializer
	output logic                           tx_data_is_ctl,
	output pcs_code_pkg::code_group_t      tx_data
);

	pcs_code_pkg::tx_state_t tx_state;
	pcs_code_pkg::tx_state_t idle_after_frame;	// /I1/ or /I2/ after carrier extend
	logic                    tx_phase;	// High while tx_data sits on an even position
	logic                    tx_en;

	assign tx_en = gmii_tx_en && link_up;	// Link down means idles only

	// Positive running disparity needs /I1/ to bring it back negative
	assign idle_after_frame = tx_disparity_negative ? pcs_code_pkg::TX_I2_0 :
		pcs_code_pkg::TX_I1_0;

	always_ff @(posedge clk_125mhz or negedge arst_n) begin
		if (!arst_n) begin
			tx_state <= pcs_code_pkg::TX_I2_0;
			tx_phase <= 1'b0;
			tx_data_is_ctl <= 1'b0;
			tx_data <= '0;
		end else begin
			tx_phase <= !tx_phase;
			tx_data_is_ctl <= 1'b0;

			case (tx_state)

				//////////////////////////////////////////////////
				// Idles between frames

				pcs_code_pkg::TX_I2_0: begin
					tx_data_is_ctl <= 1'b1;
					if (tx_en) begin
						tx_data <= pcs_code_pkg::K27_7;	// /S/ eats the first preamble byte
						tx_state <= pcs_code_pkg::TX_FRAME;
					end else begin
						tx_data <= pcs_code_pkg::K28_5;
						tx_phase <= 1'b1;	// Comma is always even
						tx_state <= pcs_code_pkg::TX_I2_1;
					end
				end
				pcs_code_pkg::TX_I2_1: begin
					tx_data <= pcs_code_pkg::D16_2;	// Must finish the ordered set
					tx_state <= tx_en ? pcs_code_pkg::TX_START : pcs_code_pkg::TX_I2_0;
				end

				//////////////////////////////////////////////////
				// Packet

				pcs_code_pkg::TX_START: begin
					tx_data_is_ctl <= 1'b1;
					tx_data <= pcs_code_pkg::K27_7;
					tx_state <= pcs_code_pkg::TX_FRAME;
				end
				pcs_code_pkg::TX_FRAME: begin
					if (tx_en)
						tx_data <= gmii_tx_data;	// Straight through
					else begin
						tx_data_is_ctl <= 1'b1;
						tx_data <= pcs_code_pkg::K29_7;
						tx_state <= pcs_code_pkg::TX_TERM;
					end
				end
				pcs_code_pkg::TX_TERM: begin
					tx_data_is_ctl <= 1'b1;
					tx_data <= pcs_code_pkg::K23_7;
					// /T/ on odd position needs a second /R/
					tx_state <= tx_phase ? idle_after_frame : pcs_code_pkg::TX_PAD;
				end
				pcs_code_pkg::TX_PAD: begin
					tx_data_is_ctl <= 1'b1;
					tx_data <= pcs_code_pkg::K23_7;
					tx_state <= idle_after_frame;
				end

				// Disparity fix
				pcs_code_pkg::TX_I1_0: begin
					tx_data_is_ctl <= 1'b1;
					tx_data <= pcs_code_pkg::K28_5;
					tx_phase <= 1'b1;
					tx_state <= pcs_code_pkg::TX_I1_1;
				end
				pcs_code_pkg::TX_I1_1: begin
					tx_data <= pcs_code_pkg::D5_6;
					tx_state <= pcs_code_pkg::TX_I2_0;
				end

				default: tx_state <= pcs_code_pkg::TX_I2_0;

			endcase
		end
	end

endmodule

`default_nettype wire

/* project.f */
hw/pcs_code_pkg.sv
hw/pcs_link_pkg.sv
hw/rx_ordered_set_parser.sv
hw/link_monitor.sv
hw/rx_frame_decoder.sv
hw/tx_frame_encoder.sv
hw/pcs_top.sv
test/pcs_checker.sv
test/pcs_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module pcs_tb -o pcs_sim

sim_output=$(./obj_dir/pcs_sim 2>&1) || true
echo "$sim_output"

grep -qx "No errors" <<< "$sim_output"

/* test/pcs_checker.sv */
`default_nettype none
`timescale 1ns/1ns

module pcs_checker (
	input  wire logic                      clk_125mhz,
	input  wire logic                      arst_n,
	input  wire logic                      tx_data_is_ctl,
	input  wire pcs_code_pkg::code_group_t tx_data,
	input  wire logic                      link_up
);

	logic tx_comma;	// K28.5 on the wire
	logic tx_ctl_legal;	// Control groups the encoder may send

	assign tx_comma = tx_data_is_ctl && (tx_data == pcs_code_pkg::K28_5);
	assign tx_ctl_legal = (tx_data == pcs_code_pkg::K28_5) || (tx_data == pcs_code_pkg::K27_7) ||
		(tx_data == pcs_code_pkg::K29_7) || (tx_data == pcs_code_pkg::K23_7);

	//////////////////////////////////////////////////
	// Transmit code-group stream

	comma_tail: assert property (@(posedge clk_125mhz) disable iff (!arst_n)
		tx_comma |=> !tx_data_is_ctl &&
			((tx_data == pcs_code_pkg::D16_2) || (tx_data == pcs_code_pkg::D5_6)))
		else $error("K28.5 on tx not followed by D16.2 or D5.6");

	ctl_set: assert property (@(posedge clk_125mhz) disable iff (!arst_n)
		tx_data_is_ctl |-> tx_ctl_legal)
		else $error("Unexpected control group on tx: %h", tx_data);

	// Link stays down while reset is held
	link_in_reset: assert property (@(posedge clk_125mhz) !arst_n |=> !link_up)
		else $error("link_up high during reset");

endmodule

bind pcs_top pcs_checker checker_i (
	.clk_125mhz     (clk_125mhz),
	.arst_n         (arst_n),
	.tx_data_is_ctl (tx_data_is_ctl),
	.tx_data        (tx_data),
	.link_up        (link_up)
);

`default_nettype wire

/* test/pcs_tb.sv */
`default_nettype none
`timescale 1ns/1ns

module pcs_tb;

	localparam int unsigned SEED = 32'h5e34_b0b2;
	localparam int ROWS = 7;
	localparam int INJ_NONE = 0;	// Plain frame
	localparam int INJ_VMID = 1;	// /V/ replaces one payload group
	localparam int INJ_CFG = 2;		// /C1/ set after the frame
	localparam int INJ_BURST = 3;	// Symbol errors after the frame
	localparam int DISP_RANDOM = 2;	// Disparity bit drawn per frame
	localparam int V_OFFSET = 12;	// Groups after /S/, always inside the payload
	localparam int GAP_CYCLES = 16;	// Idles between rows
	localparam int CNT_FRAME = 0;
	localparam int CNT_TAIL = 1;
	localparam int CNT_FALL = 2;

	//////////////////////////////////////////////////
	// Frame table: payload length, injection, disparity

	int row_len [ROWS] = '{46, 64, 30, 20, 50, 40, 25};
	int row_kind [ROWS] = '{INJ_NONE, INJ_NONE, INJ_VMID, INJ_CFG, INJ_NONE, INJ_BURST, INJ_NONE};
	int row_disp [ROWS] = '{0, 1, DISP_RANDOM, 0, DISP_RANDOM, 1, 0};

	logic clk_125mhz = 1'b0;
	logic arst_n = 1'b0;
	logic rx_data_valid = 1'b0;
	logic rx_data_is_ctl = 1'b0;
	pcs_code_pkg::code_group_t rx_data = '0;
	logic rx_disparity_err = 1'b0;
	logic rx_symbol_err = 1'b0;
	logic gmii_tx_en = 1'b0;
	pcs_code_pkg::code_group_t gmii_tx_data = '0;
	logic tx_disparity_negative = 1'b0;
	logic link_up;
	logic gmii_rx_en;
	logic gmii_rx_er;
	pcs_code_pkg::code_group_t gmii_rx_data;
	logic tx_data_is_ctl;
	pcs_code_pkg::code_group_t tx_data;

	// Injection mux controls
	logic inj_active = 1'b0;
	logic inj_ctl = 1'b0;
	pcs_code_pkg::code_group_t inj_data = '0;
	logic inj_sym_err = 1'b0;
	logic v_armed = 1'b0;	// Swap one payload group for /V/
	int since_start = 1000;	// Tx groups since the last /S/

	int error_count = 0;
	int timeout_count = 0;
	pcs_code_pkg::code_group_t sent_payload [$];

	pcs_top dut_i (.*);

	initial begin
		forever #4 clk_125mhz = ~clk_125mhz;	// 125 MHz
	end

	//////////////////////////////////////////////////
	// Loopback with injection

	always @(posedge clk_125mhz) begin
		rx_data_valid <= 1'b1;
		rx_disparity_err <= 1'b0;
		rx_symbol_err <= inj_sym_err;
		if (tx_data_is_ctl && (tx_data == pcs_code_pkg::K27_7))
			since_start <= 0;
		else if (since_start < 1000)
			since_start <= since_start + 1;
		if (inj_active) begin
			rx_data_is_ctl <= inj_ctl;
			rx_data <= inj_data;
		end else if (v_armed && (since_start == V_OFFSET)) begin
			rx_data_is_ctl <= 1'b1;	// Error propagation mid-frame
			rx_data <= pcs_code_pkg::K30_7;
		end else begin
			rx_data_is_ctl <= tx_data_is_ctl;
			rx_data <= tx_data;
		end
	end

	// Receive monitor, one byte queue per frame
	pcs_code_pkg::code_group_t rx_bytes [$];
	pcs_code_pkg::code_group_t frame_bytes [$];
	logic rx_er_now = 1'b0;
	logic frame_er = 1'b0;
	int frame_count = 0;

	always @(posedge clk_125mhz) begin
		if (gmii_rx_en) begin
			rx_bytes.push_back(gmii_rx_data);
			if (gmii_rx_er)
				rx_er_now = 1'b1;
		end else if (rx_bytes.size() > 0) begin	// Frame just ended
			frame_bytes = rx_bytes;
			frame_er <= rx_er_now || gmii_rx_er;
			frame_count <= frame_count + 1;
			rx_bytes.delete();
			rx_er_now = 1'b0;
		end
	end

	// Tx monitor, second half of the first idle after /T/
	logic after_term = 1'b0;
	logic want_tail = 1'b0;
	pcs_code_pkg::code_group_t idle_tail = '0;
	int tail_count = 0;

	always @(posedge clk_125mhz) begin
		if (want_tail) begin
			idle_tail <= tx_data;
			tail_count <= tail_count + 1;
			want_tail <= 1'b0;
		end else if (tx_data_is_ctl && (tx_data == pcs_code_pkg::K29_7))
			after_term <= 1'b1;
		else if (after_term && tx_data_is_ctl && (tx_data == pcs_code_pkg::K28_5)) begin
			after_term <= 1'b0;
			want_tail <= 1'b1;	// Next group is D5.6 or D16.2
		end
	end

	// Link drop counter, catches one-cycle drops too
	logic link_up_q = 1'b0;
	int link_fall_count = 0;

	always @(posedge clk_125mhz) begin
		link_up_q <= link_up;
		if (link_up_q && !link_up)
			link_fall_count <= link_fall_count + 1;
	end

	//////////////////////////////////////////////////
	// Reporting and waits

	task automatic report_mismatch(input string name, input int expected, input int actual);
		error_count++;
		$display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
	endtask

	task automatic report_timeout(input string what);
		timeout_count++;
		$display("Timed out waiting for %s", what);
	endtask

	function automatic int event_count(input int which);
		case (which)
			CNT_FRAME: return frame_count;
			CNT_TAIL: return tail_count;
			default: return link_fall_count;
		endcase
	endfunction

	task automatic wait_count_change(input int which, input int old, input int limit,
		input string what);
		int n;
		n = 0;
		while ((event_count(which) == old) && (n < limit)) begin
			@(posedge clk_125mhz);
			n++;
		end
		if (event_count(which) == old)
			report_timeout(what);
	endtask

	task automatic wait_link_up(input int limit, input string what);
		int n;
		n = 0;
		while (!link_up && (n < limit)) begin
			@(posedge clk_125mhz);
			n++;
		end
		if (!link_up)
			report_timeout(what);
	endtask

	//////////////////////////////////////////////////
	// Stimulus

	task automatic send_frame(input int len);
		pcs_code_pkg::code_group_t b;
		int k;
		sent_payload.delete();
		for (k = 0; k < 8; k++) begin	// Seven preamble bytes and the SFD
			@(posedge clk_125mhz);
			gmii_tx_en <= 1'b1;
			gmii_tx_data <= (k == 7) ? 8'hD5 : pcs_code_pkg::PREAMBLE_BYTE;
		end
		for (k = 0; k < len; k++) begin
			b = pcs_code_pkg::code_group_t'($urandom);
			sent_payload.push_back(b);
			@(posedge clk_125mhz);
			gmii_tx_en <= 1'b1;
			gmii_tx_data <= b;
		end
		@(posedge clk_125mhz);
		gmii_tx_en <= 1'b0;
		gmii_tx_data <= '0;
	endtask

	task automatic inject_cfg_set;
		pcs_code_pkg::code_group_t grp [4];
		int k;
		grp[0] = pcs_code_pkg::K28_5;
		grp[1] = pcs_code_pkg::D21_5;	// /C1/
		grp[2] = 8'h20;	// Config register, full duplex
		grp[3] = 8'h01;
		for (k = 0; k < 4; k++) begin
			@(posedge clk_125mhz);
			inj_active <= 1'b1;
			inj_ctl <= (k == 0);
			inj_data <= grp[k];
		end
		@(posedge clk_125mhz);
		inj_active <= 1'b0;
	endtask

	// Twice the limit so a window edge inside the burst still leaves one window over it
	task automatic inject_error_burst;
		int k;
		for (k = 0; k < 2 * int'(pcs_link_pkg::ERROR_LIMIT); k++) begin
			@(posedge clk_125mhz);
			inj_sym_err <= 1'b1;
		end
		@(posedge clk_125mhz);
		inj_sym_err <= 1'b0;
	endtask

	// Leading preamble bytes, SFD, then the exact payload
	task automatic check_frame(input string name);
		int idx;
		int k;
		idx = 0;
		if (frame_bytes.size() < 2) begin
			error_count++;
			$display("%s: received frame has only %0d bytes", name, frame_bytes.size());
			return;
		end
		while ((idx < frame_bytes.size()) && (frame_bytes[idx] == pcs_code_pkg::PREAMBLE_BYTE))
			idx++;
		if (idx == 0)
			report_mismatch({name, " preamble"}, 'h55, int'(frame_bytes[0]));
		if (idx >= frame_bytes.size()) begin
			error_count++;
			$display("%s: received frame holds only preamble bytes", name);
			return;
		end
		if (frame_bytes[idx] != 8'hD5)
			report_mismatch({name, " sfd"}, 'hD5, int'(frame_bytes[idx]));
		idx++;
		if ((frame_bytes.size() - idx) != sent_payload.size())
			report_mismatch({name, " payload length"}, sent_payload.size(),
				frame_bytes.size() - idx);
		else begin
			for (k = 0; k < sent_payload.size(); k++) begin
				if (frame_bytes[idx + k] != sent_payload[k])
					report_mismatch($sformatf("%s byte %0d", name, k), int'(sent_payload[k]),
						int'(frame_bytes[idx + k]));
			end
		end
	endtask

	task automatic run_row(input int r);
		string name;
		logic disp;
		int falls_before;
		int frames_before;
		int tails_before;
		pcs_code_pkg::code_group_t tail_exp;
		name = $sformatf("row %0d", r);
		if (row_disp[r] == DISP_RANDOM)
			disp = (($urandom % 2) == 1);
		else
			disp = (row_disp[r] == 1);
		tail_exp = disp ? pcs_code_pkg::D16_2 : pcs_code_pkg::D5_6;	// Negative keeps /I2/
		falls_before = link_fall_count;
		frames_before = frame_count;
		tails_before = tail_count;
		@(posedge clk_125mhz);
		tx_disparity_negative <= disp;
		v_armed <= (row_kind[r] == INJ_VMID);
		send_frame(row_len[r]);
		wait_count_change(CNT_FRAME, frames_before, 64, {name, " received frame"});
		wait_count_change(CNT_TAIL, tails_before, 32, {name, " idle after frame"});
		v_armed <= 1'b0;

		if (frame_count != frames_before) begin
			if (row_kind[r] == INJ_VMID) begin
				if (!frame_er)
					report_mismatch({name, " gmii_rx_er"}, 1, 0);
			end else begin
				if (frame_er)
					report_mismatch({name, " gmii_rx_er"}, 0, 1);
				check_frame(name);
			end
		end
		if (idle_tail != tail_exp)
			report_mismatch({name, " idle tail"}, int'(tail_exp), int'(idle_tail));

		repeat (GAP_CYCLES) @(posedge clk_125mhz);
		case (row_kind[r])
			INJ_CFG: begin
				inject_cfg_set();
				wait_count_change(CNT_FALL, falls_before, 32, {name, " link drop on /C/"});
				wait_link_up(100, {name, " link up after /C/"});
			end
			INJ_BURST: begin
				inject_error_burst();
				wait_count_change(CNT_FALL, falls_before,
					2 * int'(pcs_link_pkg::ERROR_WINDOW_CYCLES), {name, " link drop on errors"});
				wait_link_up(100, {name, " link up after errors"});
			end
			default: begin
				if (link_fall_count != falls_before)
					report_mismatch({name, " link drops"}, 0, link_fall_count - falls_before);
				if (!link_up)
					report_mismatch({name, " link_up"}, 1, 0);
			end
		endcase
	endtask

	//////////////////////////////////////////////////
	// Main sequence

	initial begin
		int r;
		void'($urandom(SEED));
		repeat (4) @(posedge clk_125mhz);
		arst_n <= 1'b1;
		wait_link_up(100, "link up after reset");	// Looped-back idles only
		for (r = 0; r < ROWS; r++)
			run_row(r);
		$display("Mismatches: %0d, timeouts: %0d", error_count, timeout_count);
		if ((error_count == 0) && (timeout_count == 0))
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire
